//--- verilog.f
rtl/adc_c2h_pkg.sv
rtl/lane_ctrl_if.sv
rtl/acq_sequencer.sv
rtl/channel_lane_packer.sv
rtl/c2h_stream_fifo.sv
rtl/adc_c2h_producer.sv
bench/tb_adc_c2h_producer.sv

//--- Bender.yml
package:
  name: adc_c2h_producer

sources:
  - rtl/adc_c2h_pkg.sv
  - rtl/lane_ctrl_if.sv
  - rtl/acq_sequencer.sv
  - rtl/channel_lane_packer.sv
  - rtl/c2h_stream_fifo.sv
  - rtl/adc_c2h_producer.sv
  - target: test
    files:
      - bench/tb_adc_c2h_producer.sv

//--- bench/adc_input.txt
// ch0 ch1 ch2 ch3 ch4 ch5 ch6 ch7 (18-bit hex), big_endian flag, ready cycles per 25 (hex)
// lines 0-11 run before the mid-run reset, lines 12-17 after it
2a3c1 3f001 21234 35678 29abc 3def0 2468a 3bcde 0 19
31111 22222 33333 24444 35555 26666 37777 28888 1 19
2f0f0 30f0f 2cafe 3beef 2dead 3face 2b0b0 3c0c0 0 00
20001 30002 20003 30004 20005 30006 20007 30008 0 00
3a5c1 25a3e 3c3c3 2e1e1 3f00f 20ff0 31f2e 2d4b6 1 00
27654 38765 29876 3a987 2ba98 3cba9 2dcba 3edcb 0 00
21357 3579b 29bdf 3df13 25793 39b17 2ace5 3e024 0 00
3ffff 20000 3ffff 20000 3ffff 20000 3ffff 20000 1 00
2c001 3c002 2c003 3c004 2c005 3c006 2c007 3c008 0 00
34321 24321 34322 24322 34323 24323 34324 24324 0 00
2abcd 3bcda 2cdab 3dabc 2e0e0 3f1f1 20202 31313 1 19
3d00d 2d11d 3d22d 2d33d 3d44d 2d55d 3d66d 2d77d 0 19
28a8a 39b9b 2acac 3bdbd 2cece 3dfdf 2e0e0 3f1f1 1 19
21f21 32f32 23f43 34f54 25f65 36f76 27f87 38f98 0 03
3b00b 2c11c 3d22d 2e33e 3f44f 20550 31661 22772 1 03
2f2f2 3e3e3 2d4d4 3c5c5 2b6b6 3a7a7 29898 38989 0 19
3aaaa 2bbbb 3cccc 2dddd 3eeee 2ffff 31111 22222 0 0c
24680 3579a 2468b 3579c 2468d 3579e 2468f 35790 1 19

//--- bench/tb_adc_c2h_producer.sv
/*
 * testbench for the ADC C2H stream producer
 * plays sample periods from a stimulus file with varying ready duty,
 * resets mid-run and checks every stream beat against the lane format
 */
`timescale 1ns/1ps

module tb_adc_c2h_producer
    import adc_c2h_pkg::*;
();

    localparam int N_LINES       = 18;
    // lines before the mid-run reset
    localparam int SEG1          = 12;
    localparam int N_COLS        = 10;
    localparam int PKT_LOG2      = 2;
    localparam int PERIOD        = 25;
    localparam int DRAIN_TIMEOUT = 500;
    localparam int BUS_WIDTH     = ADC_DATA_WIDTH * N_CHANNELS / 2;

    logic                   adc_data_clk;
    logic                   acq_on;
    logic [PHASE_WIDTH-1:0] adc_clk_cnt;
    logic [BUS_WIDTH-1:0]   adc_a_data;
    logic [BUS_WIDTH-1:0]   adc_b_data;
    logic                   big_endian;
    logic                   m_axis_tready;
    logic                   m_axis_tvalid;
    stream_word_t           m_axis_tdata;
    logic                   m_axis_tlast;

    // raw file contents, ten columns per line
    logic [ADC_DATA_WIDTH-1:0] stim [N_LINES*N_COLS];
    // per-sample values, indexed by sample number since the last reset
    adc_sample_t chan_arr [N_LINES][N_CHANNELS];
    logic        be_arr [N_LINES];
    int          duty_arr [N_LINES];
    int          nstored = 0;
    int          errors  = 0;

    // receiver state
    int word_idx          = 0;
    int pairs             = 0;
    int last_sample       = -1;
    int cur               = -1;
    bit first_after_reset = 1'b1;

    adc_c2h_producer #(
        .FIFO_DEPTH       (16),
        .PROG_FULL_MARGIN (4),
        .PKT_SAMPLES_LOG2 (PKT_LOG2)
    ) adc_c2h_producer_i (
        .adc_data_clk  (adc_data_clk),
        .acq_on        (acq_on),
        .adc_clk_cnt   (adc_clk_cnt),
        .adc_a_data    (adc_a_data),
        .adc_b_data    (adc_b_data),
        .big_endian    (big_endian),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    initial begin
        adc_data_clk = 1'b0;
        forever #5 adc_data_clk = ~adc_data_clk;
    end

    // ********************
    // checks and reference model
    // ********************
    task automatic check_value(input string name, input logic [STREAM_WIDTH-1:0] actual,
                               input logic [STREAM_WIDTH-1:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic lane_t byte_swap(input lane_t v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    // lane k of word w: channel k+4w, zeros, counter byte k+4w
    function automatic stream_word_t expected_word(input int n, input int w);
        stream_word_t  word;
        lane_t         lane;
        sample_count_t cnt;
        int            k;
        cnt = CNT_WIDTH'(n);
        for (k = 0; k < N_LANES; k++) begin
            lane = {chan_arr[n][k + N_LANES*w], 6'b0, cnt[8*(k + N_LANES*w) +: 8]};
            word[LANE_WIDTH*k +: LANE_WIDTH] = be_arr[n] ? byte_swap(lane) : lane;
        end
        return word;
    endfunction

    // counter bytes sit in the low byte, or the high byte when swapped
    function automatic int sample_number(input stream_word_t d);
        logic [31:0] n_le;
        logic [31:0] n_be;
        int          k;
        for (k = 0; k < N_LANES; k++) begin
            n_le[8*k +: 8] = d[LANE_WIDTH*k +: 8];
            n_be[8*k +: 8] = d[LANE_WIDTH*k + 24 +: 8];
        end
        if (n_le < nstored && !be_arr[n_le]) begin
            return int'(n_le);
        end
        if (n_be < nstored && be_arr[n_be]) begin
            return int'(n_be);
        end
        return -1;
    endfunction

    task automatic receive_beat();
        int m;
        if (word_idx == 0) begin
            cur = sample_number(m_axis_tdata);
            if (cur < 0) begin
                errors++;
                $display("Error: word 0 carries no known sample number (0x%0h)", m_axis_tdata);
            end else begin
                check_value("m_axis_tdata", m_axis_tdata, expected_word(cur, 0));
                if (first_after_reset) begin
                    check_value("first sample after reset", cur, 0);
                end else if (cur <= last_sample) begin
                    errors++;
                    $display("Error: sample %0d arrived after sample %0d", cur, last_sample);
                end
                // two full-ready periods in a row leave the FIFO below its threshold
                for (m = last_sample + 1; m < cur; m++) begin
                    if (m > 0 && duty_arr[m] == PERIOD && duty_arr[m-1] == PERIOD) begin
                        errors++;
                        $display("Error: sample %0d dropped although ready was always high", m);
                    end
                end
            end
            check_value("m_axis_tlast", m_axis_tlast, 1'b0);
            first_after_reset = 1'b0;
            word_idx = 1;
        end else begin
            if (cur >= 0) begin
                check_value("m_axis_tdata", m_axis_tdata, expected_word(cur, 1));
                last_sample = cur;
            end
            // every fourth word 1 closes a packet
            check_value("m_axis_tlast", m_axis_tlast,
                        (pairs % (1 << PKT_LOG2)) == ((1 << PKT_LOG2) - 1));
            pairs++;
            word_idx = 0;
        end
    endtask

    // stream receiver, state cleared while acq_on is low
    initial begin
        forever begin
            @(posedge adc_data_clk);
            if (acq_on !== 1'b1) begin
                if (m_axis_tvalid === 1'b1) begin
                    errors++;
                    $display("Error: m_axis_tvalid high while acq_on is low");
                end
                word_idx = 0;
                pairs = 0;
                last_sample = -1;
                first_after_reset = 1'b1;
            end else if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
                receive_beat();
            end
        end
    end

    // ********************
    // stimulus
    // ********************
    task automatic drive_period(input int line, input int n);
        logic [BUS_WIDTH-1:0] a_bus;
        logic [BUS_WIDTH-1:0] b_bus;
        int                   j;
        int                   c;
        for (j = 0; j < N_CHANNELS; j++) begin
            chan_arr[n][j] = stim[line*N_COLS + j];
        end
        be_arr[n]   = stim[line*N_COLS + 8][0];
        duty_arr[n] = int'(stim[line*N_COLS + 9]);
        nstored     = n + 1;
        // even channels on side a, odd channels on side b
        for (j = 0; j < N_CHANNELS / 2; j++) begin
            a_bus[j*ADC_DATA_WIDTH +: ADC_DATA_WIDTH] = chan_arr[n][2*j];
            b_bus[j*ADC_DATA_WIDTH +: ADC_DATA_WIDTH] = chan_arr[n][2*j + 1];
        end
        for (c = 0; c < PERIOD; c++) begin
            @(posedge adc_data_clk);
            adc_clk_cnt   <= PHASE_WIDTH'(c);
            m_axis_tready <= (c < duty_arr[n]);
            if (c == 0) begin
                adc_a_data <= a_bus;
                adc_b_data <= b_bus;
                big_endian <= be_arr[n];
            end
        end
    endtask

    task automatic apply_reset();
        int c;
        @(posedge adc_data_clk);
        acq_on      <= 1'b0;
        adc_clk_cnt <= '0;
        for (c = 0; c < 10; c++) begin
            @(posedge adc_data_clk);
        end
        nstored = 0;
        acq_on <= 1'b1;
    endtask

    initial begin
        int line;
        int wait_cycles;
        acq_on        = 1'b0;
        adc_clk_cnt   = '0;
        adc_a_data    = '0;
        adc_b_data    = '0;
        big_endian    = 1'b0;
        m_axis_tready = 1'b0;
        $readmemh("bench/adc_input.txt", stim);
        if (stim[0] === 'x) begin
            errors++;
            $display("Error: stimulus file could not be read");
        end

        apply_reset();
        for (line = 0; line < SEG1; line++) begin
            drive_period(line, line);
        end
        // the final sample of the segment ran with full ready and must have arrived
        check_value("last sample before reset", last_sample, SEG1 - 1);
        // mid-run reset, numbering restarts at sample 0
        apply_reset();
        for (line = SEG1; line < N_LINES; line++) begin
            drive_period(line, line - SEG1);
        end

        // park the phase outside the active phases and drain
        @(posedge adc_data_clk);
        adc_clk_cnt   <= '0;
        m_axis_tready <= 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge adc_data_clk);
            wait_cycles++;
        end while (m_axis_tvalid === 1'b1 && wait_cycles < DRAIN_TIMEOUT);
        if (m_axis_tvalid === 1'b1) begin
            errors++;
            $display("Error: stream did not drain within %0d cycles", DRAIN_TIMEOUT);
        end
        check_value("pairs after reset", pairs, N_LINES - SEG1);
        check_value("last sample after reset", last_sample, N_LINES - SEG1 - 1);

        $display("pairs after reset: %0d, errors: %0d", pairs, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- rtl/adc_c2h_producer.sv
/*
 * ADC C2H stream producer, top level
 * packs eight ADC channels and a 64-bit sample counter into two
 * 128-bit words per sample, buffers them and drives a valid/ready stream
 */
`timescale 1ns/1ps

module adc_c2h_producer
    import adc_c2h_pkg::*;
#(
    parameter int FIFO_DEPTH       = 64,
    parameter int PROG_FULL_MARGIN = 4,
    parameter int PKT_SAMPLES_LOG2 = 10
) (
    input  logic                                      adc_data_clk,
    input  logic                                      acq_on,
    input  logic [PHASE_WIDTH-1:0]                    adc_clk_cnt,
    input  logic [ADC_DATA_WIDTH*N_CHANNELS/2-1:0]    adc_a_data,
    input  logic [ADC_DATA_WIDTH*N_CHANNELS/2-1:0]    adc_b_data,
    input  logic                                      big_endian,
    input  logic                                      m_axis_tready,
    output logic                                      m_axis_tvalid,
    output logic [STREAM_WIDTH-1:0]                   m_axis_tdata,
    output logic                                      m_axis_tlast
);

    // channels in sample order
    wire adc_sample_t            adc_ch [N_CHANNELS];
    // lane 0 in the low bits
    wire lane_t [N_LANES-1:0]    lane_word;

    logic      wr_valid;
    logic      wr_last;
    logic      prog_full;
    c2h_beat_t wr_beat;
    c2h_beat_t rd_beat;

    lane_ctrl_if ctrl ();

    // ********************
    // channel mapping
    // ********************
    // even channels from side a, odd channels from side b
    for (genvar j = 0; j < N_CHANNELS / 2; j++) begin : g_chan
        assign adc_ch[2*j]     = adc_a_data[j*ADC_DATA_WIDTH +: ADC_DATA_WIDTH];
        assign adc_ch[2*j + 1] = adc_b_data[j*ADC_DATA_WIDTH +: ADC_DATA_WIDTH];
    end

    acq_sequencer #(
        .PKT_SAMPLES_LOG2 (PKT_SAMPLES_LOG2)
    ) acq_sequencer_i (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_clk_cnt  (adc_clk_cnt),
        .big_endian   (big_endian),
        .prog_full    (prog_full),
        .ctrl         (ctrl.seq),
        .wr_valid     (wr_valid),
        .wr_last      (wr_last)
    );

    // ********************
    // lane packers
    // ********************
    // lane k carries channel k in word 0 and channel k+4 in word 1
    for (genvar k = 0; k < N_LANES; k++) begin : g_lane
        channel_lane_packer #(
            .LANE (k)
        ) channel_lane_packer_i (
            .adc_data_clk (adc_data_clk),
            .acq_on       (acq_on),
            .ctrl         (ctrl.lane),
            .chan_lo      (adc_ch[k]),
            .chan_hi      (adc_ch[k + N_LANES]),
            .lane_out     (lane_word[k])
        );
    end

    assign wr_beat.data = lane_word;
    assign wr_beat.last = wr_last;

    // ********************
    // stream FIFO
    // ********************
    c2h_stream_fifo #(
        .DEPTH            (FIFO_DEPTH),
        .PROG_FULL_MARGIN (PROG_FULL_MARGIN),
        .payload_t        (c2h_beat_t)
    ) c2h_stream_fifo_i (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .wr_valid     (wr_valid),
        .wr_data      (wr_beat),
        .rd_ready     (m_axis_tready),
        .prog_full    (prog_full),
        .rd_valid     (m_axis_tvalid),
        .rd_data      (rd_beat)
    );

    assign m_axis_tdata = rd_beat.data;
    // qualified so an empty buffer never shows a stale marker
    assign m_axis_tlast = m_axis_tvalid && rd_beat.last;

endmodule

//--- rtl/c2h_stream_fifo.sv
/*
 * C2H stream FIFO
 * single-clock circular buffer with first-word fall-through output,
 * an occupancy counter and a programmable-full flag
 */
`timescale 1ns/1ps

module c2h_stream_fifo #(
    parameter int  DEPTH            = 64,
    parameter int  PROG_FULL_MARGIN = 4,
    parameter type payload_t        = logic
) (
    input  logic     adc_data_clk,
    input  logic     acq_on,
    input  logic     wr_valid,
    input  payload_t wr_data,
    input  logic     rd_ready,
    output logic     prog_full,
    output logic     rd_valid,
    output payload_t rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            full;
    logic            wr_en;
    logic            rd_en;

    // ********************
    // flags
    // ********************
    assign full      = (count == CW'(DEPTH));
    assign prog_full = (count >= CW'(DEPTH - PROG_FULL_MARGIN));
    // head of the buffer is always on the output
    assign rd_valid  = (count != '0);
    assign rd_data   = mem[rd_ptr];

    // writes beyond full are ignored
    assign wr_en = wr_valid && !full;
    assign rd_en = rd_valid && rd_ready;

    // storage
    always_ff @(posedge adc_data_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ********************
    // pointers and occupancy
    // ********************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leave the count unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/channel_lane_packer.sv
/*
 * channel lane packer
 * builds one 32-bit lane from a channel sample and one counter byte,
 * then applies the byte order in a second register stage
 */
`timescale 1ns/1ps

module channel_lane_packer
    import adc_c2h_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic        adc_data_clk,
    input  logic        acq_on,
    lane_ctrl_if.lane   ctrl,
    input  adc_sample_t chan_lo,
    input  adc_sample_t chan_hi,
    output lane_t       lane_out
);

    // zero bits between sample and counter byte
    localparam int PAD_WIDTH = LANE_WIDTH - ADC_DATA_WIDTH - 8;
    // counter byte positions for word 0 and word 1
    localparam int BYTE_LO   = 8 * LANE;
    localparam int BYTE_HI   = 8 * (LANE + N_LANES);

    adc_sample_t chan_sel;
    logic [7:0]  cnt_byte;
    lane_t       lane_raw;
    lane_t       lane_swap;
    logic        load_d;

    // word 1 takes channel k+4 and the upper counter half
    assign chan_sel = ctrl.word_sel ? chan_hi : chan_lo;
    assign cnt_byte = ctrl.word_sel ? ctrl.sample_count[BYTE_HI +: 8]
                                    : ctrl.sample_count[BYTE_LO +: 8];

    // all four bytes of the lane reversed
    assign lane_swap = {<<8{lane_raw}};

    // ********************
    // pipeline control
    // ********************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            load_d <= 1'b0;
        end else begin
            load_d <= ctrl.load;
        end
    end

    // ********************
    // lane registers
    // ********************
    always_ff @(posedge adc_data_clk) begin
        // stage 1, raw lane one cycle after load
        if (ctrl.load) begin
            lane_raw <= {chan_sel, {PAD_WIDTH{1'b0}}, cnt_byte};
        end
        // stage 2, byte order, two cycles after load
        if (load_d) begin
            lane_out <= ctrl.big_endian ? lane_swap : lane_raw;
        end
    end

endmodule

//--- rtl/acq_sequencer.sv
/*
 * acquisition sequencer
 * decodes the phase of each sample period, keeps the sample and packet
 * counters, decides once per sample whether both words enter the FIFO
 * and marks the last word of each packet
 */
`timescale 1ns/1ps

module acq_sequencer
    import adc_c2h_pkg::*;
#(
    parameter int PKT_SAMPLES_LOG2 = 10
) (
    input  logic                   adc_data_clk,
    input  logic                   acq_on,
    input  logic [PHASE_WIDTH-1:0] adc_clk_cnt,
    input  logic                   big_endian,
    input  logic                   prog_full,
    lane_ctrl_if.seq               ctrl,
    output logic                   wr_valid,
    output logic                   wr_last
);

    // free-running sample number, bytes go into the lanes
    sample_count_t               sample_cnt;
    // written samples within the current packet
    logic [PKT_SAMPLES_LOG2-1:0] pkt_cnt;
    // byte order latched at the start of a sample
    logic                        big_endian_q;

    // ********************
    // lane control
    // ********************
    // load strobes are decoded straight from the phase counter
    assign ctrl.load         = (adc_clk_cnt == PH_WORD0) || (adc_clk_cnt == PH_WORD1);
    assign ctrl.word_sel     = (adc_clk_cnt == PH_WORD1);
    assign ctrl.sample_count = sample_cnt;
    assign ctrl.big_endian   = big_endian_q;

    // ********************
    // sample sequencing
    // ********************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_valid     <= 1'b0;
            wr_last      <= 1'b0;
            sample_cnt   <= '0;
            pkt_cnt      <= '0;
            big_endian_q <= 1'b0;
        end else begin
            case (adc_clk_cnt)
                PH_WORD0: begin
                    // byte order is frozen here so both words agree
                    big_endian_q <= big_endian;
                    wr_valid     <= 1'b0;
                    wr_last      <= 1'b0;
                end
                PH_WORD1: begin
                    // whole sample written or whole sample dropped
                    wr_valid <= !prog_full;
                    wr_last  <= 1'b0;
                end
                PH_PACKET: begin
                    // wr_valid stays up, word 1 follows in the next cycle
                    if (wr_valid) begin
                        pkt_cnt <= pkt_cnt + 1'b1;
                        // counter about to wrap, word 1 closes the packet
                        wr_last <= &pkt_cnt;
                    end
                end
                PH_ADVANCE: begin
                    wr_valid   <= 1'b0;
                    wr_last    <= 1'b0;
                    // dropped samples still count, gaps show downstream
                    sample_cnt <= sample_cnt + 1'b1;
                end
                default: begin
                    wr_valid <= 1'b0;
                    wr_last  <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- rtl/lane_ctrl_if.sv
/*
 * lane control bundle
 * carries the load strobe, word select, sample counter and byte order
 * from the acquisition sequencer to the four lane packers
 */
`timescale 1ns/1ps

interface lane_ctrl_if
    import adc_c2h_pkg::*;
();

    // one-cycle strobe in phase 1 and phase 2
    logic          load;
    // 0 selects word 0, 1 selects word 1
    logic          word_sel;
    // counter of the sample being packed
    sample_count_t sample_count;
    // byte order, held for the whole sample
    logic          big_endian;

    modport seq (
        output load,
        output word_sel,
        output sample_count,
        output big_endian
    );

    modport lane (
        input load,
        input word_sel,
        input sample_count,
        input big_endian
    );

endinterface

//--- rtl/adc_c2h_pkg.sv
/*
 * ADC C2H stream producer, shared definitions
 * widths, phase values of the sample period, lane and word types
 * and the beat stored in the stream FIFO
 */
package adc_c2h_pkg;

    // ********************
    // widths
    // ********************
    localparam int ADC_DATA_WIDTH = 18;
    localparam int N_CHANNELS     = 8;
    localparam int N_LANES        = 4;
    localparam int LANE_WIDTH     = 32;
    localparam int STREAM_WIDTH   = N_LANES * LANE_WIDTH;
    localparam int CNT_WIDTH      = 64;
    localparam int PHASE_WIDTH    = 6;

    // ********************
    // phases of adc_clk_cnt
    // ********************
    // word 0 packed
    localparam logic [PHASE_WIDTH-1:0] PH_WORD0   = 6'd1;
    // word 1 packed, write decision
    localparam logic [PHASE_WIDTH-1:0] PH_WORD1   = 6'd2;
    // packet count and last flag
    localparam logic [PHASE_WIDTH-1:0] PH_PACKET  = 6'd3;
    // sample counter advances
    localparam logic [PHASE_WIDTH-1:0] PH_ADVANCE = 6'd4;

    // ********************
    // types
    // ********************
    typedef logic [ADC_DATA_WIDTH-1:0] adc_sample_t;
    typedef logic [LANE_WIDTH-1:0]     lane_t;
    typedef logic [STREAM_WIDTH-1:0]   stream_word_t;
    typedef logic [CNT_WIDTH-1:0]      sample_count_t;

    // one FIFO entry, word plus packet end marker
    typedef struct packed {
        stream_word_t data;
        logic         last;
    } c2h_beat_t;

endpackage
